//--- sim.f
hdl/video_timing_pkg.sv
hdl/vdp_color_pkg.sv
hdl/video_timing_ctrl.sv
hdl/line_doubler.sv
hdl/color_to_rgb.sv
hdl/video_out_top.sv
verif/video_out_checker.sv
verif/video_out_tb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert --top-module video_out_tb -f sim.f

out=$(./obj_dir/Vvideo_out_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx '=== PASS ==='; then
   exit 0
fi
exit 1

//--- verif/video_out_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_out_tb;
   import vdp_color_pkg::*;
   import video_timing_pkg::*;

   localparam int VDP_CLK_DIV   = 4;
   localparam int ACTIVE_PIXELS = 16;
   localparam int LINE_PIXELS   = 24;
   localparam int ACTIVE_LINES  = 4;
   localparam int FRAME_LINES   = 6;
   localparam int HSYNC_PIXELS  = 2;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 5;
   localparam int CHECK_FRAMES = 3;
   localparam int FRAME_STB    = 2 * LINE_PIXELS * FRAME_LINES;   // VGA pixels per frame
   localparam int FRAME_CLKS   = VDP_CLK_DIV * LINE_PIXELS * FRAME_LINES;
   localparam int WATCHDOG_NS  = (4 * FRAME_CLKS + RESET_CYCLES) * CLK_PERIOD * 2;

   localparam int T_RESET    = 0;
   localparam int T_PALETTE  = 1;
   localparam int T_DOUBLING = 2;
   localparam int T_OVERLAY  = 3;
   localparam int T_BLANKING = 4;
   localparam int NUM_TESTS  = 5;

   logic        clk = 1'b0;
   logic        reset_i = 1'b1;
   color_idx_t  vdp_color_i = '0;
   color_idx_t  overlay_color_i = '0;
   logic        pixel_req;
   logic [3:0]  vga_r;
   logic [3:0]  vga_g;
   logic [3:0]  vga_b;
   logic        vga_hs;
   logic        vga_vs;
   logic        pix_stb;
   rgb444_t     pin_rgb;

   string       test_names [NUM_TESTS] =
      '{"reset", "palette", "doubling", "overlay", "blanking_sync"};
   int          checks [NUM_TESTS];
   int          errors [NUM_TESTS];
   logic [31:0] lcg_state = 32'd91;
   color_idx_t  req_colors [ACTIVE_LINES][ACTIVE_PIXELS];   // Colours taken per VDP line
   rgb444_t     first_half [ACTIVE_PIXELS];
   color_idx_t  next_ovl = '0;   // Overlay driven for the coming VGA line
   color_idx_t  line_ovl = '0;
   int          edge_cnt = 0;
   int          req_cnt = 0;
   int          stb_cnt = 0;
   int          frame_stb = 0;
   int          hs_run = 0;
   int          hs_pulses = 0;
   int          vs_low = 0;
   int          vs_falls = 0;
   logic        vs_prev = 1'b1;
   int          frames_done = 0;

   video_out_top #(
      .VDP_CLK_DIV(VDP_CLK_DIV), .ACTIVE_PIXELS(ACTIVE_PIXELS),
      .LINE_PIXELS(LINE_PIXELS), .ACTIVE_LINES(ACTIVE_LINES),
      .FRAME_LINES(FRAME_LINES), .HSYNC_PIXELS(HSYNC_PIXELS)
   ) u_dut (
      .clk(clk), .reset_i(reset_i),
      .vdp_color_i(vdp_color_i), .overlay_color_i(overlay_color_i),
      .pixel_req_o(pixel_req),
      .vga_r_o(vga_r), .vga_g_o(vga_g), .vga_b_o(vga_b),
      .vga_hs_o(vga_hs), .vga_vs_o(vga_vs),
      .pix_stb_o(pix_stb)
   );

   assign pin_rgb = {vga_r, vga_g, vga_b};

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input int test, input string what, input int expected,
                              input int actual);
      checks[test]++;
      if (actual != expected) begin
         errors[test]++;
         $display("Error %s: %s expected 'h%0h, actual 'h%0h",
                  test_names[test], what, expected, actual);
      end
   endtask

   task automatic check_reset_pins();
      check_value(T_RESET, "pixel_req_o", 0, int'(pixel_req));
      check_value(T_RESET, "pix_stb_o", 0, int'(pix_stb));
      check_value(T_RESET, "rgb", 0, int'(pin_rgb));
      check_value(T_RESET, "vga_hs_o", 1, int'(vga_hs));
      check_value(T_RESET, "vga_vs_o", 1, int'(vga_vs));
   endtask

   task automatic record_request();
      req_colors[(req_cnt / ACTIVE_PIXELS) % ACTIVE_LINES][req_cnt % ACTIVE_PIXELS] = vdp_color_i;
      req_cnt++;
      lcg_state = lcg_step(lcg_state);
      vdp_color_i <= color_idx_t'(lcg_state[27:24]);
   endtask

   task automatic count_syncs();
      if (vga_vs && !vs_prev) begin   // End of vsync closes a frame
         check_value(T_BLANKING, "hsync pulses per frame", 2 * FRAME_LINES, hs_pulses);
         check_value(T_BLANKING, "vsync periods per frame", 1, vs_falls);
         check_value(T_BLANKING, "vsync length", 2 * LINE_PIXELS, vs_low);
         check_value(T_BLANKING, "pix_stb_o per frame", FRAME_STB, frame_stb);
         hs_pulses = 0;
         vs_falls  = 0;
         vs_low    = 0;
         frame_stb = 0;
         frames_done++;
      end
      frame_stb++;
      if (!vga_vs) begin
         vs_low++;
         if (vs_prev) begin
            vs_falls++;
         end
      end
      vs_prev = vga_vs;
      if (!vga_hs) begin
         hs_run++;
      end else if (hs_run > 0) begin
         check_value(T_BLANKING, "hsync width", HSYNC_PIXELS, hs_run);
         hs_pulses++;
         hs_run = 0;
      end
   endtask

   task automatic check_strobe();
      int      col;
      int      vga_line;
      int      vdp_y;
      int      shown;
      logic    active;
      rgb444_t expected;
      col      = stb_cnt % LINE_PIXELS;
      vga_line = stb_cnt / LINE_PIXELS;
      vdp_y    = (vga_line / 2) % FRAME_LINES;
      shown    = (vdp_y + FRAME_LINES - 1) % FRAME_LINES;   // Previous VDP line is on screen
      active   = (col < ACTIVE_PIXELS) && (shown < ACTIVE_LINES);
      if (col == 0) begin
         line_ovl = next_ovl;
      end
      if (!active) begin
         check_value(T_BLANKING, "rgb outside active", 0, int'(pin_rgb));
      end else begin
         expected = palette_rgb(req_colors[shown][col]);
         if (vga_line % 2 == 0) begin
            first_half[col] = expected;   // Doubled colour the second line has to repeat
         end
         if (line_ovl != '0) begin
            expected = palette_rgb(line_ovl);
            check_value(T_OVERLAY, "rgb", int'(expected), int'(pin_rgb));
         end else begin
            check_value(T_PALETTE, "rgb", int'(expected), int'(pin_rgb));
            if (vga_line % 2 == 1) begin
               check_value(T_DOUBLING, "second line rgb", int'(first_half[col]),
                           int'(pin_rgb));
            end
         end
      end
      check_value(T_BLANKING, "vga_vs_o", (vdp_y == FRAME_LINES - 1) ? 0 : 1, int'(vga_vs));
      if (col == ACTIVE_PIXELS) begin   // Only blanked pixels are in flight here
         lcg_state = lcg_step(lcg_state);
         next_ovl  = lcg_state[31] ? color_idx_t'(lcg_state[27:24]) : '0;
         overlay_color_i <= next_ovl;
      end
      stb_cnt++;
   endtask

   always @(posedge clk) begin
      if (edge_cnt >= 1 && edge_cnt <= RESET_CYCLES + 1) begin
         check_reset_pins();
      end
      if (edge_cnt == RESET_CYCLES + 1) begin
         $display("Test %s finished: %0d checks, %0d errors",
                  test_names[T_RESET], checks[T_RESET], errors[T_RESET]);
      end
      edge_cnt++;
      if (!reset_i) begin
         if (pixel_req) begin
            record_request();
         end
         if (pix_stb) begin
            count_syncs();
            check_strobe();
         end
      end
   end

   initial begin
      int total_checks;
      int total_errors;
      int assert_fails;
      total_checks = 0;
      total_errors = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_i <= 1'b0;
      while (frames_done < CHECK_FRAMES) begin
         @(negedge clk);
      end
      for (int t = 0; t < NUM_TESTS; t++) begin
         if (t != T_RESET) begin
            $display("Test %s finished: %0d checks, %0d errors",
                     test_names[t], checks[t], errors[t]);
         end
         if (checks[t] == 0) begin
            $display("Test %s ran no checks at all", test_names[t]);
            total_errors++;
         end
         total_checks += checks[t];
         total_errors += errors[t];
      end
      assert_fails = u_dut.u_timing.u_checker.fail_count;
      $display("Total: %0d checks, %0d errors, %0d assertion failures",
               total_checks, total_errors, assert_fails);
      if (total_errors == 0 && assert_fails == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the DUT did not complete %0d frames in time", CHECK_FRAMES);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/video_out_checker.sv
`timescale 1ns/1ps
`default_nettype none

module video_out_checker #(
   parameter int ACTIVE_PIXELS = 16,
   parameter int LINE_PIXELS   = 24,
   parameter int ACTIVE_LINES  = 4,
   parameter int FRAME_LINES   = 6
) (
   input  wire                            clk,
   input  wire                            reset_i,
   input  wire                            vdp_pix_en_i,
   input  wire                            vga_pix_en_i,
   input  wire                            pixel_req_i,
   input  wire                            wr_bank_i,
   input  wire video_timing_pkg::pix_x_t  vdp_x_i,
   input  wire video_timing_pkg::line_y_t vdp_y_i
);
   import video_timing_pkg::*;

   localparam pix_x_t  X_ACTIVE = pix_x_t'(ACTIVE_PIXELS);
   localparam pix_x_t  X_LAST   = pix_x_t'(LINE_PIXELS - 1);
   localparam line_y_t Y_ACTIVE = line_y_t'(ACTIVE_LINES);
   localparam line_y_t Y_LAST   = line_y_t'(FRAME_LINES - 1);

   logic [2:0] vga_seen;   // VGA enables since the last VDP enable
   logic [2:0] vga_total;
   pix_x_t     ref_x;      // VDP raster position counted from the enables alone
   line_y_t    ref_y;
   int         fail_count = 0;

   assign vga_total = vga_seen + {2'b00, vga_pix_en_i};

   always_ff @(posedge clk) begin
      if (reset_i || vdp_pix_en_i) begin
         vga_seen <= '0;
      end else begin
         vga_seen <= vga_total;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ref_x <= '0;
         ref_y <= '0;
      end else if (vdp_pix_en_i) begin
         if (ref_x == X_LAST) begin
            ref_x <= '0;
            ref_y <= (ref_y == Y_LAST) ? '0 : ref_y + 1'b1;
         end else begin
            ref_x <= ref_x + 1'b1;
         end
      end
   end

   a_vga_twice: assert property (@(posedge clk) disable iff (reset_i)
      vdp_pix_en_i |-> (vga_total == 3'd2))
      else begin
         $error("VGA enable fired %0d times in one VDP pixel period", vga_total);
         fail_count++;
      end

   a_req_active: assert property (@(posedge clk) disable iff (reset_i)
      pixel_req_i |-> vdp_pix_en_i && (ref_x < X_ACTIVE) && (ref_y < Y_ACTIVE))
      else begin
         $error("pixel_req outside the active region at x %0d y %0d", vdp_x_i, vdp_y_i);
         fail_count++;
      end

   // A bank swap must land on the first VDP pixel of a line
   a_bank_at_line_start: assert property (@(posedge clk) disable iff (reset_i)
      (wr_bank_i != $past(wr_bank_i)) |-> (vdp_x_i == '0) && $past(vdp_pix_en_i))
      else begin
         $error("wr_bank changed away from a VDP line start at x %0d", vdp_x_i);
         fail_count++;
      end

endmodule

bind video_timing_ctrl video_out_checker #(
   .ACTIVE_PIXELS(ACTIVE_PIXELS),
   .LINE_PIXELS(LINE_PIXELS),
   .ACTIVE_LINES(ACTIVE_LINES),
   .FRAME_LINES(FRAME_LINES)
) u_checker (
   .clk(clk), .reset_i(reset_i),
   .vdp_pix_en_i(vdp_pix_en_o), .vga_pix_en_i(vga_pix_en_o),
   .pixel_req_i(pixel_req_o), .wr_bank_i(wr_bank_o),
   .vdp_x_i(vdp_x), .vdp_y_i(vdp_y)
);

`default_nettype wire

//--- hdl/video_out_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_out_top #(
   parameter int VDP_CLK_DIV   = 4,
   parameter int ACTIVE_PIXELS = 16,
   parameter int LINE_PIXELS   = 24,
   parameter int ACTIVE_LINES  = 4,
   parameter int FRAME_LINES   = 6,
   parameter int HSYNC_PIXELS  = 2
) (
   input  wire                            clk,
   input  wire                            reset_i,
   input  wire vdp_color_pkg::color_idx_t vdp_color_i,
   input  wire vdp_color_pkg::color_idx_t overlay_color_i,
   output logic                           pixel_req_o,
   output logic [3:0]                     vga_r_o,
   output logic [3:0]                     vga_g_o,
   output logic [3:0]                     vga_b_o,
   output logic                           vga_hs_o,
   output logic                           vga_vs_o,
   output logic                           pix_stb_o
);
   import vdp_color_pkg::*;
   import video_timing_pkg::*;

   logic       vga_pix_en;
   logic       wr_bank;
   pix_x_t     wr_addr;
   pix_x_t     rd_addr;
   sync_t      vga_sync;
   sync_t      pin_sync;
   color_idx_t rd_color;
   rgb444_t    pin_rgb;

   video_timing_ctrl #(
      .VDP_CLK_DIV(VDP_CLK_DIV), .ACTIVE_PIXELS(ACTIVE_PIXELS),
      .LINE_PIXELS(LINE_PIXELS), .ACTIVE_LINES(ACTIVE_LINES),
      .FRAME_LINES(FRAME_LINES), .HSYNC_PIXELS(HSYNC_PIXELS)
   ) u_timing (
      .clk(clk), .reset_i(reset_i),
      .vdp_pix_en_o(), .vga_pix_en_o(vga_pix_en),
      .pixel_req_o(pixel_req_o),
      .wr_addr_o(wr_addr), .rd_addr_o(rd_addr),
      .wr_bank_o(wr_bank), .vga_sync_o(vga_sync)
   );

   line_doubler #(.ACTIVE_PIXELS(ACTIVE_PIXELS)) u_doubler (
      .clk(clk), .reset_i(reset_i),
      .pixel_req_i(pixel_req_o), .vdp_color_i(vdp_color_i),
      .wr_addr_i(wr_addr), .wr_bank_i(wr_bank),
      .vga_pix_en_i(vga_pix_en), .rd_addr_i(rd_addr),
      .rd_color_o(rd_color)
   );

   color_to_rgb u_rgb (
      .clk(clk), .reset_i(reset_i),
      .color_i(rd_color), .overlay_color_i(overlay_color_i),
      .vga_sync_i(vga_sync), .pix_en_i(vga_pix_en),
      .rgb_o(pin_rgb), .sync_o(pin_sync), .pix_stb_o(pix_stb_o)
   );

   assign vga_r_o  = pin_rgb.r;
   assign vga_g_o  = pin_rgb.g;
   assign vga_b_o  = pin_rgb.b;
   assign vga_hs_o = ~pin_sync.hsync;   // Monitor expects active low syncs
   assign vga_vs_o = ~pin_sync.vsync;

endmodule

`default_nettype wire

//--- hdl/color_to_rgb.sv
`timescale 1ns/1ps
`default_nettype none

module color_to_rgb (
   input  wire                            clk,
   input  wire                            reset_i,
   input  wire vdp_color_pkg::color_idx_t color_i,
   input  wire vdp_color_pkg::color_idx_t overlay_color_i,
   input  wire video_timing_pkg::sync_t   vga_sync_i,
   input  wire                            pix_en_i,
   output vdp_color_pkg::rgb444_t         rgb_o,
   output video_timing_pkg::sync_t        sync_o,
   output logic                           pix_stb_o
);
   import vdp_color_pkg::*;
   import video_timing_pkg::*;

   sync_t      sync_d;
   logic       pix_en_d;
   color_idx_t sel_color;
   rgb444_t    pix_rgb;

   // First stage lines the timing up with the registered buffer read
   always_ff @(posedge clk) begin
      if (reset_i) begin
         pix_en_d <= 1'b0;
         sync_d   <= '0;
      end else begin
         pix_en_d <= pix_en_i;
         if (pix_en_i) begin
            sync_d <= vga_sync_i;
         end
      end
   end

   always_comb begin
      sel_color = (overlay_color_i != '0) ? overlay_color_i : color_i;   // Overlay wins
      pix_rgb   = sync_d.active ? palette_rgb(sel_color) : '0;
   end

   // Output stage holds every pin until the next pixel
   always_ff @(posedge clk) begin
      if (reset_i) begin
         pix_stb_o <= 1'b0;
         rgb_o     <= '0;
         sync_o    <= '0;
      end else begin
         pix_stb_o <= pix_en_d;
         if (pix_en_d) begin
            rgb_o  <= pix_rgb;
            sync_o <= sync_d;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/line_doubler.sv
`timescale 1ns/1ps
`default_nettype none

module line_doubler #(
   parameter int ACTIVE_PIXELS = 16
) (
   input  wire                          clk,
   input  wire                          reset_i,
   input  wire                          pixel_req_i,
   input  wire vdp_color_pkg::color_idx_t vdp_color_i,
   input  wire video_timing_pkg::pix_x_t  wr_addr_i,
   input  wire                          wr_bank_i,
   input  wire                          vga_pix_en_i,
   input  wire video_timing_pkg::pix_x_t  rd_addr_i,
   output vdp_color_pkg::color_idx_t    rd_color_o
);
   import vdp_color_pkg::*;
   import video_timing_pkg::*;

   localparam int     ADDR_W   = (ACTIVE_PIXELS > 1) ? $clog2(ACTIVE_PIXELS) : 1;
   localparam pix_x_t X_ACTIVE = pix_x_t'(ACTIVE_PIXELS);

   // Two line buffers, one filled by the VDP while the other is shown twice
   color_idx_t line_mem [0:1][0:ACTIVE_PIXELS-1];

   logic rd_bank;
   logic wr_ok;
   logic rd_ok;

   assign rd_bank = ~wr_bank_i;
   assign wr_ok   = pixel_req_i && (wr_addr_i < X_ACTIVE);
   assign rd_ok   = rd_addr_i < X_ACTIVE;

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         line_mem[wr_bank_i][wr_addr_i[ADDR_W-1:0]] <= vdp_color_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         rd_color_o <= '0;
      end else if (vga_pix_en_i) begin
         if (rd_ok) begin
            rd_color_o <= line_mem[rd_bank][rd_addr_i[ADDR_W-1:0]];
         end else begin
            rd_color_o <= '0;   // Beyond the buffer the pixel is blanked anyway
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/video_timing_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing_ctrl #(
   parameter int VDP_CLK_DIV   = 4,
   parameter int ACTIVE_PIXELS = 16,
   parameter int LINE_PIXELS   = 24,
   parameter int ACTIVE_LINES  = 4,
   parameter int FRAME_LINES   = 6,
   parameter int HSYNC_PIXELS  = 2
) (
   input  wire                       clk,
   input  wire                       reset_i,
   output logic                      vdp_pix_en_o,
   output logic                      vga_pix_en_o,
   output logic                      pixel_req_o,
   output video_timing_pkg::pix_x_t  wr_addr_o,
   output video_timing_pkg::pix_x_t  rd_addr_o,
   output logic                      wr_bank_o,
   output video_timing_pkg::sync_t   vga_sync_o
);
   import video_timing_pkg::*;

   typedef enum logic {
      FIRST_HALF,
      SECOND_HALF
   } line_phase_t;

   localparam int               DIV_W    = $clog2(VDP_CLK_DIV);
   localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(VDP_CLK_DIV / 2 - 1);
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(VDP_CLK_DIV - 1);

   localparam pix_x_t  X_ACTIVE = pix_x_t'(ACTIVE_PIXELS);
   localparam pix_x_t  X_LAST   = pix_x_t'(LINE_PIXELS - 1);
   // Hsync sits in the middle of the horizontal blanking interval
   localparam pix_x_t  HS_START =
      pix_x_t'(ACTIVE_PIXELS + (LINE_PIXELS - ACTIVE_PIXELS - HSYNC_PIXELS) / 2);
   localparam pix_x_t  HS_END   = pix_x_t'(int'(HS_START) + HSYNC_PIXELS);
   localparam line_y_t Y_ACTIVE = line_y_t'(ACTIVE_LINES);
   localparam line_y_t Y_LAST   = line_y_t'(FRAME_LINES - 1);

   logic [DIV_W-1:0] div_cnt;
   pix_x_t           vdp_x;
   line_y_t          vdp_y;
   line_y_t          prev_y;
   pix_x_t           vga_x;
   line_phase_t      phase;
   logic             vga_line_end;
   logic             vdp_line_end;

   assign vdp_pix_en_o = (div_cnt == DIV_LAST);
   assign vga_pix_en_o = (div_cnt == DIV_HALF) || (div_cnt == DIV_LAST);

   always_ff @(posedge clk) begin
      if (reset_i || div_cnt == DIV_LAST) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         vdp_x <= '0;
      end else if (vdp_pix_en_o) begin
         vdp_x <= (vdp_x == X_LAST) ? '0 : vdp_x + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         vga_x <= '0;
      end else if (vga_pix_en_o) begin
         vga_x <= (vga_x == X_LAST) ? '0 : vga_x + 1'b1;
      end
   end

   assign vga_line_end = vga_pix_en_o && (vga_x == X_LAST);
   assign vdp_line_end = vga_line_end && (phase == SECOND_HALF);   // Coincides with vdp_x wrap

   always_ff @(posedge clk) begin
      if (reset_i) begin
         phase <= FIRST_HALF;
      end else if (vga_line_end) begin
         case (phase)
            FIRST_HALF: phase <= SECOND_HALF;
            default:    phase <= FIRST_HALF;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         vdp_y     <= '0;
         wr_bank_o <= 1'b0;
      end else if (vdp_line_end) begin
         vdp_y     <= (vdp_y == Y_LAST) ? '0 : vdp_y + 1'b1;
         wr_bank_o <= ~wr_bank_o;   // Finished line becomes the read bank
      end
   end

   // The VGA side always shows the line written during the previous VDP line
   assign prev_y = (vdp_y == '0) ? Y_LAST : vdp_y - 1'b1;

   assign pixel_req_o = vdp_pix_en_o && (vdp_x < X_ACTIVE) && (vdp_y < Y_ACTIVE);
   assign wr_addr_o   = vdp_x;
   assign rd_addr_o   = vga_x;

   always_comb begin
      vga_sync_o.hsync  = (vga_x >= HS_START) && (vga_x < HS_END);
      vga_sync_o.vsync  = (vdp_y == Y_LAST);
      vga_sync_o.active = (vga_x < X_ACTIVE) && (prev_y < Y_ACTIVE);
   end

endmodule

`default_nettype wire

//--- hdl/vdp_color_pkg.sv
`default_nettype none

package vdp_color_pkg;

   typedef logic [3:0] color_idx_t;   // Index 0 is transparent

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb444_t;

   // TMS9918 palette reduced to four bits per channel
   function automatic rgb444_t palette_rgb(input color_idx_t idx);
      logic [11:0] val;
      case (idx)
         4'h0:    val = 12'h000;   // Transparent shows as black
         4'h1:    val = 12'h000;
         4'h2:    val = 12'h2C4;
         4'h3:    val = 12'h5D7;
         4'h4:    val = 12'h55E;
         4'h5:    val = 12'h77F;
         4'h6:    val = 12'hD54;
         4'h7:    val = 12'h4EF;
         4'h8:    val = 12'hF55;
         4'h9:    val = 12'hF77;
         4'hA:    val = 12'hDC5;
         4'hB:    val = 12'hEC8;
         4'hC:    val = 12'h2B3;
         4'hD:    val = 12'hC5B;
         4'hE:    val = 12'hCCC;
         default: val = 12'hFFF;
      endcase
      return rgb444_t'(val);
   endfunction

endpackage

`default_nettype wire

//--- hdl/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

   // Column position counted in VDP pixels
   typedef logic [7:0] pix_x_t;

   // Line position counted in VDP lines
   typedef logic [7:0] line_y_t;

   // Sync levels are active high until the pins
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic active;   // Inside the visible window
   } sync_t;

endpackage

`default_nettype wire
